/* logic/replay_pkg.sv */
// Packet replay shared definitions
`default_nettype none

package replay_pkg;

  localparam int NUM_QUEUES    = 4;
  localparam int QID_W         = 2;
  localparam int DATA_W        = 32;
  localparam int ADDR_W        = 8;
  localparam int COUNT_W       = 8;
  localparam int EGRESS_DEPTH  = 4;
  localparam int INGRESS_DEPTH = 4;

  // Width of an egress FIFO fill level
  localparam int FILL_W = $clog2(EGRESS_DEPTH + 1);

  typedef logic [QID_W-1:0]  qid_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Stored word, also the egress payload
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } mem_word_t;

  // Ingress beat with one-hot destination port
  typedef struct packed {
    logic [DATA_W-1:0]     data;
    logic                  last;
    logic [NUM_QUEUES-1:0] dst_port;
  } stream_beat_t;

  // Per-queue window and replay count
  typedef struct packed {
    addr_t              addr_low;
    addr_t              addr_high;
    logic [COUNT_W-1:0] replay_count;
  } queue_cfg_t;

  // One extra bit so a full 256-word window still fits
  typedef logic [ADDR_W:0] word_count_t;

endpackage

`default_nettype wire

/* logic/stream_fifo.sv */
// Synchronous stream FIFO
`default_nettype none

module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  wire logic                       axi_aclk,
  input  wire logic                       rst_n,
  input  wire payload_t                   in_data,
  input  wire logic                       in_valid,
  output logic                            in_ready,
  output payload_t                        out_data,
  output logic                            out_valid,
  input  wire logic                       out_ready,
  output logic [$clog2(DEPTH+1)-1:0]      fill
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t             mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic                 push;
  logic                 pop;

  assign in_ready  = (fill != DEPTH[$clog2(DEPTH+1)-1:0]);
  assign out_valid = (fill != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge axi_aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the level unchanged
      if (push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !push) begin
        fill <= fill - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/capture_writer.sv */
// Ingress steering and capture
`default_nettype none

module capture_writer
  import replay_pkg::*;
(
  input  wire logic                  axi_aclk,
  input  wire logic                  rst_n,
  input  wire stream_beat_t          beat,
  input  wire logic                  beat_valid,
  input  wire queue_cfg_t            cfg [NUM_QUEUES],
  input  wire logic [NUM_QUEUES-1:0] enable,
  output logic                       wr_en,
  output addr_t                      wr_addr,
  output mem_word_t                  wr_word,
  output word_count_t                stored_count [NUM_QUEUES]
);

  logic  in_pkt;
  qid_t  cur_q;
  logic  cur_keep;

  qid_t  first_q;
  qid_t  sel_q;
  logic  sel_keep;
  logic  has_room;
  logic  do_write;

  function automatic qid_t lowest_bit(input logic [NUM_QUEUES-1:0] bits);
    qid_t idx;
    idx = '0;
    for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
      if (bits[i]) begin
        idx = qid_t'(i);
      end
    end
    return idx;
  endfunction

  // Queue is chosen on the first beat and held until last
  assign first_q  = lowest_bit(beat.dst_port);
  assign sel_q    = in_pkt ? cur_q : first_q;
  assign sel_keep = in_pkt ? cur_keep : ((|beat.dst_port) && enable[first_q]);

  // Window full once addr_low plus count passes addr_high
  assign has_room = (word_count_t'(cfg[sel_q].addr_low) + stored_count[sel_q])
                    <= word_count_t'(cfg[sel_q].addr_high);
  assign do_write = beat_valid && sel_keep && has_room;

  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      in_pkt   <= 1'b0;
      cur_q    <= '0;
      cur_keep <= 1'b0;
      wr_en    <= 1'b0;
      for (int q = 0; q < NUM_QUEUES; q++) begin
        stored_count[q] <= '0;
      end
    end else begin
      wr_en <= do_write;
      if (beat_valid) begin
        in_pkt <= !beat.last;
        if (!in_pkt) begin
          cur_q    <= first_q;
          cur_keep <= sel_keep;
        end
      end
      if (do_write) begin
        stored_count[sel_q] <= stored_count[sel_q] + 1'b1;
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (do_write) begin
      wr_addr      <= cfg[sel_q].addr_low + stored_count[sel_q][ADDR_W-1:0];
      wr_word.data <= beat.data;
      wr_word.last <= beat.last;
    end
  end

endmodule

`default_nettype wire

/* logic/packet_memory.sv */
// Packet word memory
`default_nettype none

module packet_memory
  import replay_pkg::*;
(
  input  wire logic      axi_aclk,
  input  wire logic      wr_en,
  input  wire addr_t     wr_addr,
  input  wire mem_word_t wr_word,
  input  wire logic      rd_en,
  input  wire addr_t     rd_addr,
  output mem_word_t      rd_word
);

  mem_word_t mem [2**ADDR_W];

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_word;
    end
  end

  // One cycle read latency
  always_ff @(posedge axi_aclk) begin
    if (rd_en) begin
      rd_word <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* logic/replay_reader.sv */
// Round-robin replay reader
`default_nettype none

module replay_reader
  import replay_pkg::*;
(
  input  wire logic                  axi_aclk,
  input  wire logic                  rst_n,
  input  wire queue_cfg_t            cfg [NUM_QUEUES],
  input  wire logic [NUM_QUEUES-1:0] start_replay,
  input  wire word_count_t           stored_count [NUM_QUEUES],
  input  wire logic [FILL_W-1:0]     fill [NUM_QUEUES],
  output logic                       rd_en,
  output addr_t                      rd_addr,
  output logic [NUM_QUEUES-1:0]      push
);

  logic [NUM_QUEUES-1:0] busy;
  logic [COUNT_W-1:0]    pass_left [NUM_QUEUES];
  word_count_t           offset [NUM_QUEUES];
  qid_t                  rr_ptr;

  // Queue tag of the read issued last cycle
  logic                  tag_valid;
  qid_t                  tag_q;

  logic [NUM_QUEUES-1:0] credit;
  logic [NUM_QUEUES-1:0] eligible;
  qid_t                  sel_q;

  always_comb begin
    for (int q = 0; q < NUM_QUEUES; q++) begin
      push[q]   = tag_valid && (tag_q == qid_t'(q));
      // A pending push already owns one FIFO slot
      credit[q] = (int'(fill[q]) + int'(push[q])) < EGRESS_DEPTH;
    end
  end

  assign eligible = busy & credit;

  always_comb begin
    qid_t idx;
    sel_q = rr_ptr;
    rd_en = 1'b0;
    for (int k = NUM_QUEUES - 1; k >= 0; k--) begin
      idx = rr_ptr + qid_t'(k);
      if (eligible[idx]) begin
        sel_q = idx;
        rd_en = 1'b1;
      end
    end
  end

  assign rd_addr = cfg[sel_q].addr_low + offset[sel_q][ADDR_W-1:0];

  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      busy      <= '0;
      rr_ptr    <= '0;
      tag_valid <= 1'b0;
      tag_q     <= '0;
      for (int q = 0; q < NUM_QUEUES; q++) begin
        pass_left[q] <= '0;
        offset[q]    <= '0;
      end
    end else begin
      tag_valid <= rd_en;
      tag_q     <= sel_q;

      if (rd_en) begin
        rr_ptr <= sel_q + 1'b1;
        if (offset[sel_q] + 1'b1 >= stored_count[sel_q]) begin
          // End of a pass
          offset[sel_q]    <= '0;
          pass_left[sel_q] <= pass_left[sel_q] - 1'b1;
          if (pass_left[sel_q] == COUNT_W'(1)) begin
            busy[sel_q] <= 1'b0;
          end
        end else begin
          offset[sel_q] <= offset[sel_q] + 1'b1;
        end
      end

      // Starts on a busy queue are dropped
      for (int q = 0; q < NUM_QUEUES; q++) begin
        if (start_replay[q] && !busy[q] &&
            cfg[q].replay_count != '0 && stored_count[q] != '0) begin
          busy[q]      <= 1'b1;
          pass_left[q] <= cfg[q].replay_count;
          offset[q]    <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/pcap_replay_engine.sv */
// Packet capture and replay engine
`default_nettype none

module pcap_replay_engine
  import replay_pkg::*;
(
  input  wire logic                  axi_aclk,
  input  wire logic                  rst_n,

  input  wire stream_beat_t          s_beat,
  input  wire logic                  s_valid,
  output logic                       s_ready,

  input  wire queue_cfg_t            cfg [NUM_QUEUES],
  input  wire logic [NUM_QUEUES-1:0] enable,
  input  wire logic [NUM_QUEUES-1:0] start_replay,

  output mem_word_t                  m_beat [NUM_QUEUES],
  output logic [NUM_QUEUES-1:0]      m_valid,
  input  wire logic [NUM_QUEUES-1:0] m_ready
);

  stream_beat_t          ing_beat;
  logic                  ing_valid;

  logic                  wr_en;
  addr_t                 wr_addr;
  mem_word_t             wr_word;
  word_count_t           stored_count [NUM_QUEUES];

  logic                  rd_en;
  addr_t                 rd_addr;
  mem_word_t             rd_word;

  logic [NUM_QUEUES-1:0] push;
  logic [FILL_W-1:0]     egress_fill [NUM_QUEUES];

  // Writer drains a beat every cycle, so the FIFO is always ready to pop
  stream_fifo #(
    .payload_t (stream_beat_t),
    .DEPTH     (INGRESS_DEPTH)
  ) u_ingress_fifo (
    .axi_aclk  (axi_aclk),
    .rst_n     (rst_n),
    .in_data   (s_beat),
    .in_valid  (s_valid),
    .in_ready  (s_ready),
    .out_data  (ing_beat),
    .out_valid (ing_valid),
    .out_ready (1'b1),
    .fill      ()
  );

  capture_writer u_capture_writer (
    .axi_aclk     (axi_aclk),
    .rst_n        (rst_n),
    .beat         (ing_beat),
    .beat_valid   (ing_valid),
    .cfg          (cfg),
    .enable       (enable),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_word      (wr_word),
    .stored_count (stored_count)
  );

  packet_memory u_packet_memory (
    .axi_aclk (axi_aclk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_word  (wr_word),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_word  (rd_word)
  );

  replay_reader u_replay_reader (
    .axi_aclk     (axi_aclk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .start_replay (start_replay),
    .stored_count (stored_count),
    .fill         (egress_fill),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .push         (push)
  );

  // Reader credit keeps in_ready high on every push
  for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_egress
    stream_fifo #(
      .payload_t (mem_word_t),
      .DEPTH     (EGRESS_DEPTH)
    ) u_egress_fifo (
      .axi_aclk  (axi_aclk),
      .rst_n     (rst_n),
      .in_data   (rd_word),
      .in_valid  (push[q]),
      .in_ready  (),
      .out_data  (m_beat[q]),
      .out_valid (m_valid[q]),
      .out_ready (m_ready[q]),
      .fill      (egress_fill[q])
    );
  end

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
// Testbench clock and reset
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held low for three rising edges
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* verification/pcap_replay_engine_props.sv */
// Replay engine stream properties
`default_nettype none

module pcap_replay_engine_props
  import replay_pkg::*;
(
  input wire logic                  axi_aclk,
  input wire logic                  rst_n,
  input wire logic                  s_valid,
  input wire logic                  s_ready,
  input wire mem_word_t             m_beat [NUM_QUEUES],
  input wire logic [NUM_QUEUES-1:0] m_valid,
  input wire logic [NUM_QUEUES-1:0] m_ready
);

  for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
    // Stalled egress beat holds
    assert property (@(posedge axi_aclk) disable iff (!rst_n)
      m_valid[q] && !m_ready[q] |=> m_valid[q] && $stable(m_beat[q]))
      else $error("egress queue %0d beat changed while stalled", q);

    assert property (@(posedge axi_aclk) !rst_n |=> !m_valid[q])
      else $error("egress queue %0d valid high right after reset", q);
  end

  assert property (@(posedge axi_aclk) !rst_n |-> !(s_valid && s_ready))
    else $error("ingress transfer while reset is asserted");

endmodule

bind pcap_replay_engine pcap_replay_engine_props u_props (
  .axi_aclk (axi_aclk),
  .rst_n    (rst_n),
  .s_valid  (s_valid),
  .s_ready  (s_ready),
  .m_beat   (m_beat),
  .m_valid  (m_valid),
  .m_ready  (m_ready)
);

`default_nettype wire

/* verification/pcap_replay_engine_tb.sv */
// Packet replay engine testbench
`default_nettype none

module pcap_replay_engine_tb
  import replay_pkg::*;
();

  logic                  clk;
  logic                  rst_n;
  stream_beat_t          s_beat;
  logic                  s_valid;
  logic                  s_ready;
  queue_cfg_t            cfg [NUM_QUEUES];
  logic [NUM_QUEUES-1:0] enable;
  logic [NUM_QUEUES-1:0] start_replay;
  mem_word_t             m_beat [NUM_QUEUES];
  logic [NUM_QUEUES-1:0] m_valid;
  logic [NUM_QUEUES-1:0] m_ready = '0;

  logic [31:0] lfsr = 32'h66c0e860;
  string       test_name = "reset";
  int          cycle = 0;
  int          cycle_limit = 0;
  bit          verdict_done = 1'b0;

  // Destination and length of each ingress packet
  logic [NUM_QUEUES-1:0] pkt_dst [9] = '{4'b0001, 4'b1000, 4'b0010, 4'b0000, 4'b0100,
                                         4'b1010, 4'b0001, 4'b0100, 4'b0001};
  int                    pkt_len [9] = '{3, 3, 2, 2, 4, 3, 1, 5, 4};

  stream_beat_t beats [$];
  mem_word_t    stored_q [NUM_QUEUES][$];
  mem_word_t    expect_q [NUM_QUEUES][$];
  bit           ref_in_pkt;
  int           ref_q;
  bit           ref_keep;

  tb_clock u_clock (.clk(clk), .rst_n(rst_n));

  pcap_replay_engine u_dut (
    .axi_aclk     (clk),
    .rst_n        (rst_n),
    .s_beat       (s_beat),
    .s_valid      (s_valid),
    .s_ready      (s_ready),
    .cfg          (cfg),
    .enable       (enable),
    .start_replay (start_replay),
    .m_beat       (m_beat),
    .m_valid      (m_valid),
    .m_ready      (m_ready)
  );

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Steering, discard and window rules for one ingress beat
  function automatic void ref_capture(input stream_beat_t b);
    mem_word_t w;
    if (!ref_in_pkt) begin
      ref_keep = 1'b0;
      for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
        if (b.dst_port[i]) begin
          ref_q    = i;
          ref_keep = enable[i];
        end
      end
    end
    w.data = b.data;
    w.last = b.last;
    if (ref_keep && cfg[ref_q].addr_low + stored_q[ref_q].size() <= cfg[ref_q].addr_high) begin
      stored_q[ref_q].push_back(w);
    end
    ref_in_pkt = !b.last;
  endfunction

  // Stored words repeated replay_count times
  function automatic void ref_replay(input int q);
    for (int p = 0; p < cfg[q].replay_count; p++) begin
      for (int i = 0; i < stored_q[q].size(); i++) begin
        expect_q[q].push_back(stored_q[q][i]);
      end
    end
  endfunction

  function automatic int pending_words();
    int n;
    n = 0;
    for (int q = 0; q < NUM_QUEUES; q++) begin
      n += expect_q[q].size();
    end
    return n;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    verdict_done = 1'b1;
    $fatal(1);
  endtask

  task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
    if (act !== exp) begin
      fail_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input word_count_t exp,
                             input word_count_t act);
    if (act !== exp) begin
      fail_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  // Random gaps, a waiting beat stays until accepted
  task automatic send_beats();
    int idx;
    idx = 0;
    while (idx < beats.size()) begin
      @(posedge clk);
      if (s_valid && s_ready) begin
        idx++;
      end
      if (!s_valid || s_ready) begin
        if (idx < beats.size() && rand_bits(1) == 1) begin
          s_beat  <= beats[idx];
          s_valid <= 1'b1;
        end else begin
          s_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic wait_replay_done();
    do begin
      @(posedge clk);
    end while (pending_words() != 0 || m_valid != '0 ||
               u_dut.u_replay_reader.busy != '0 || u_dut.push != '0);
  endtask

  always @(posedge clk) begin
    m_ready <= NUM_QUEUES'(rand_bits(NUM_QUEUES));
  end

  always @(posedge clk) begin
    if (rst_n) begin
      for (int q = 0; q < NUM_QUEUES; q++) begin
        if (m_valid[q] && m_ready[q]) begin
          if (expect_q[q].size() == 0) begin
            fail_run($sformatf("Queue %0d sent a word that no replay accounts for", q));
          end else begin
            check_word($sformatf("%s q%0d", test_name, q), expect_q[q].pop_front(),
                       m_beat[q]);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle_limit != 0 && cycle > cycle_limit) begin
      fail_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    stream_beat_t b;
    s_beat       <= '0;
    s_valid      <= 1'b0;
    start_replay <= '0;
    // Queue 3 disabled, queue 2 window holds six words
    enable       <= 4'b0111;
    cfg[0] <= '{addr_low: 8'd0,  addr_high: 8'd15,  replay_count: 8'd1};
    cfg[1] <= '{addr_low: 8'd32, addr_high: 8'd47,  replay_count: 8'd3};
    cfg[2] <= '{addr_low: 8'd64, addr_high: 8'd69,  replay_count: 8'd2};
    cfg[3] <= '{addr_low: 8'd96, addr_high: 8'd111, replay_count: 8'd2};
    while (rst_n !== 1'b1) @(posedge clk);

    for (int p = 0; p < 9; p++) begin
      for (int i = 0; i < pkt_len[p]; i++) begin
        b.data     = rand_bits(DATA_W);
        b.last     = (i == pkt_len[p] - 1);
        b.dst_port = pkt_dst[p];
        beats.push_back(b);
        ref_capture(b);
      end
    end
    for (int q = 0; q < NUM_QUEUES; q++) begin
      ref_replay(q);
    end
    // Second pass on queue 1 comes later
    cycle_limit = cycle + 4 * (beats.size() + pending_words() + stored_q[1].size()) + 200;

    test_name = "capture";
    send_beats();
    do begin
      @(posedge clk);
    end while (u_dut.u_ingress_fifo.fill != '0 || u_dut.wr_en);
    for (int q = 0; q < NUM_QUEUES; q++) begin
      check_count($sformatf("capture q%0d", q), word_count_t'(stored_q[q].size()),
                  u_dut.stored_count[q]);
    end

    test_name = "concurrent_replay";
    start_replay <= '1;
    @(posedge clk);
    start_replay <= '0;
    wait_replay_done();

    // Count of zero on queue 0, one more pass on queue 1
    test_name = "recount";
    cfg[0].replay_count <= 8'd0;
    cfg[1].replay_count <= 8'd1;
    @(posedge clk);
    ref_replay(0);
    ref_replay(1);
    start_replay <= 4'b0011;
    @(posedge clk);
    start_replay <= '0;
    wait_replay_done();

    $display("No errors");
    verdict_done = 1'b1;
    $finish;
  end

  // Run stopped by an assertion before any verdict
  final begin
    if (!verdict_done) begin
      $display("Errors found");
    end
  end

endmodule

`default_nettype wire

/* pcap_replay_engine.f */
logic/replay_pkg.sv
logic/stream_fifo.sv
logic/capture_writer.sv
logic/packet_memory.sv
logic/replay_reader.sv
logic/pcap_replay_engine.sv
verification/tb_clock.sv
verification/pcap_replay_engine_props.sv
verification/pcap_replay_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the replay engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module pcap_replay_engine_tb -f pcap_replay_engine.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
